/* core_controller.f */
+incdir+include
rtl/ctrl_types_pkg.sv
rtl/hazard_types_pkg.sv
rtl/ctrl_fsm.sv
rtl/hazard_unit.sv
rtl/freeze_unit.sv
rtl/core_controller.sv
tests/clk_gen.sv
tests/core_controller_properties.sv
tests/core_controller_tb.sv

/* tests/core_controller_tb.sv */
`include "ctrl_cfg.svh"

module core_controller_tb
  import ctrl_types_pkg::*;
  import hazard_types_pkg::*;
();
  timeunit 1ns;
  timeprecision 100ps;

  // test lengths in cycles feed the watchdog budget
  localparam int RESET_CYCLES  = 6;
  localparam int BOOT_CYCLES   = 16;
  localparam int FWD_ITERS     = 24;
  localparam int HAZARD_CYCLES = 6;
  localparam int BP_CYCLES     = 3;
  localparam int BRANCH_CYCLES = 8;
  localparam int FLUSH_CYCLES  = 30;
  localparam int MARGIN_CYCLES = 40;
  localparam int WATCHDOG_NS   = 20 * (RESET_CYCLES + BOOT_CYCLES + FWD_ITERS +
                                       HAZARD_CYCLES + BP_CYCLES + BRANCH_CYCLES +
                                       FLUSH_CYCLES + MARGIN_CYCLES);

  // selectors for the level waits
  localparam int OBS_DECODING = 0;
  localparam int OBS_BUSY     = 1;
  localparam int OBS_REQ      = 2;

  logic         clk;
  logic         rst_n;
  decode_info_t dec;
  wr_ports_t    wr;
  jump_kind_e   jump_in_id;
  jump_kind_e   jump_in_ex;
  logic         branch_decision;
  logic         exc_pc_sel;
  logic         pc_valid;
  logic         lsu_ready_ex;
  logic         lsu_ready_wb;
  logic         fetch_enable;
  logic         irq_present;
  logic         instr_ack;
  logic         instr_req;
  logic         pc_set;
  pc_sel_e      pc_sel;
  logic         core_busy;
  logic         is_decoding;
  logic         illegal_insn;
  fwd_sel_t     fwd_sel;
  stall_t       stall;
  logic         deassert_we;

  // bookkeeping
  string        cur_test;
  int           test_errors;
  int           total_errors;
  int           tests_run;
  int           tests_failed;
  logic [15:0]  lfsr_q;

  clk_gen u_clk_gen (
    .clk   (clk),
    .rst_n (rst_n)
  );

  core_controller u_dut (
    .clk               (clk),
    .rst_n             (rst_n),
    .dec_i             (dec),
    .wr_i              (wr),
    .jump_in_id_i      (jump_in_id),
    .jump_in_ex_i      (jump_in_ex),
    .branch_decision_i (branch_decision),
    .exc_pc_sel_i      (exc_pc_sel),
    .pc_valid_i        (pc_valid),
    .lsu_ready_ex_i    (lsu_ready_ex),
    .lsu_ready_wb_i    (lsu_ready_wb),
    .fetch_enable_i    (fetch_enable),
    .irq_present_i     (irq_present),
    .instr_ack_i       (instr_ack),
    .instr_req_o       (instr_req),
    .pc_set_o          (pc_set),
    .pc_sel_o          (pc_sel),
    .core_busy_o       (core_busy),
    .is_decoding_o     (is_decoding),
    .illegal_insn_o    (illegal_insn),
    .fwd_sel_o         (fwd_sel),
    .stall_o           (stall),
    .deassert_we_o     (deassert_we)
  );

  //////////////////////////////////////////////////////////////////////
  // helpers
  //////////////////////////////////////////////////////////////////////

  // 16 bit fibonacci lfsr with taps 16 14 13 11 and one step per bit taken
  task automatic take_bits(input int n, output logic [15:0] val);
    logic fb;
    int   i;
    val = '0;
    for (i = 0; i < n; i++)
    begin
      fb     = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];
      lfsr_q = {lfsr_q[14:0], fb};
      val    = {val[14:0], fb};
    end
  endtask

  task automatic start_test(input string name);
    cur_test    = name;
    test_errors = 0;
  endtask

  task automatic end_test();
    $display("test %-12s %s, %0d error(s)", cur_test,
             (test_errors == 0) ? "PASS" : "FAIL", test_errors);
    tests_run++;
    total_errors += test_errors;
    if (test_errors != 0)
      tests_failed++;
  endtask

  task automatic check_value(input string sig, input logic [31:0] exp,
                             input logic [31:0] act);
    if (exp !== act)
    begin
      $display("MISMATCH test=%s signal=%s expected=%0h actual=%0h",
               cur_test, sig, exp, act);
      test_errors++;
    end
  endtask

  function automatic logic observe(input int sel);
    case (sel)
      OBS_DECODING: return is_decoding;
      OBS_BUSY:     return core_busy;
      OBS_REQ:      return instr_req;
      default:      return 1'b0;
    endcase
  endfunction

  // poll one output each falling edge until it reaches the level
  task automatic wait_level(input string what, input int sel, input logic level,
                            input int max_cycles);
    int n;
    bit seen;
    seen = 1'b0;
    for (n = 0; (n < max_cycles) && !seen; n++)
    begin
      @(negedge clk);
      #1;
      if (observe(sel) === level)
        seen = 1'b1;
    end
    if (!seen)
    begin
      $display("ERROR test=%s: %s did not go to %0b within %0d cycles",
               cur_test, what, level, max_cycles);
      test_errors++;
    end
  endtask

  // calm pipeline with enable and ack left alone
  task automatic set_quiet_inputs();
    dec             = '0;
    wr              = '0;
    jump_in_id      = NONE;
    jump_in_ex      = NONE;
    branch_decision = 1'b0;
    exc_pc_sel      = 1'b0;
    pc_valid        = 1'b1;
    lsu_ready_ex    = 1'b1;
    lsu_ready_wb    = 1'b1;
    irq_present     = 1'b0;
  endtask

  // forward select from the priority rules where c has no alu path and no x0 rule
  function automatic fwd_sel_e expected_sel(input reg_addr_t src, input logic used,
                                            input logic is_operand_c);
    fwd_sel_e sel;
    sel = SEL_REGFILE;
    if (used && wr.wb.we && (wr.wb.addr == src))
      sel = SEL_FW_WB;
    if (!is_operand_c && used && wr.alu.we && (wr.alu.addr == src))
      sel = SEL_FW_EX;
    if (!is_operand_c && (src == '0))
      sel = SEL_REGFILE;
    return sel;
  endfunction

  //////////////////////////////////////////////////////////////////////
  // directed tests
  //////////////////////////////////////////////////////////////////////

  task automatic test_boot();
    start_test("boot");
    check_value("instr_req_o", 0, instr_req);
    check_value("core_busy_o", 0, core_busy);
    check_value("pc_set_o", 0, pc_set);
    check_value("is_decoding_o", 0, is_decoding);
    @(negedge clk);
    fetch_enable = 1'b1;
    #1;
    check_value("pc_set_o", 0, pc_set);
    // BOOT_SET holds the boot pc load for one cycle
    @(negedge clk);
    #1;
    check_value("pc_set_o", 1, pc_set);
    check_value("pc_sel_o", PC_BOOT, pc_sel);
    // FIRST_FETCH requests while no ack has come yet
    @(negedge clk);
    #1;
    check_value("pc_set_o", 0, pc_set);
    check_value("instr_req_o", 1, instr_req);
    repeat (2)
    begin
      @(negedge clk);
      #1;
      check_value("is_decoding_o", 0, is_decoding);
      check_value("stall_o.id", 1, stall.id_stg);
    end
    @(negedge clk);
    instr_ack = 1'b1;
    wait_level("is_decoding_o", OBS_DECODING, 1'b1, 8);
    end_test();
  endtask

  task automatic test_forwarding();
    logic [15:0] r;
    reg_addr_t   rs1;
    reg_addr_t   rs2;
    reg_addr_t   rd;
    int          i;
    start_test("forwarding");
    for (i = 0; i < FWD_ITERS; i++)
    begin
      @(negedge clk);
      set_quiet_inputs();
      // addresses from 0..3 so that matches and x0 show up often
      take_bits(2, r);
      rs1 = reg_addr_t'(r);
      take_bits(2, r);
      rs2 = reg_addr_t'(r);
      take_bits(2, r);
      rd = reg_addr_t'(r);
      take_bits(2, r);
      wr.ex.addr = reg_addr_t'(r);
      take_bits(2, r);
      wr.wb.addr = reg_addr_t'(r);
      take_bits(2, r);
      wr.alu.addr = reg_addr_t'(r);
      take_bits(3, r);
      {wr.ex.we, wr.wb.we, wr.alu.we} = r[2:0];
      take_bits(3, r);
      {dec.rega_used, dec.regb_used, dec.regc_used} = r[2:0];
      dec.insn[`CTRL_RS1_LSB +: `CTRL_REG_AW] = rs1;
      dec.insn[`CTRL_RS2_LSB +: `CTRL_REG_AW] = rs2;
      dec.insn[`CTRL_RD_LSB +: `CTRL_REG_AW]  = rd;
      #1;
      check_value("fwd_sel_o.a", expected_sel(rs1, dec.rega_used, 1'b0), fwd_sel.a);
      check_value("fwd_sel_o.b", expected_sel(rs2, dec.regb_used, 1'b0), fwd_sel.b);
      check_value("fwd_sel_o.c", expected_sel(rd, dec.regc_used, 1'b1), fwd_sel.c);
    end
    end_test();
  endtask

  task automatic test_hazards();
    start_test("hazards");
    // load in ex writes the register read as operand a
    @(negedge clk);
    set_quiet_inputs();
    dec.insn[`CTRL_RS1_LSB +: `CTRL_REG_AW] = 5'd5;
    dec.rega_used  = 1'b1;
    wr.ex.addr     = 5'd5;
    wr.ex.we       = 1'b1;
    wr.data_req_ex = 1'b1;
    #1;
    check_value("stall_o.if", 1, stall.if_stg);
    check_value("stall_o.id", 1, stall.id_stg);
    check_value("deassert_we_o", 1, deassert_we);
    @(negedge clk);
    wr.ex.addr = 5'd6;
    #1;
    check_value("stall_o.if", 0, stall.if_stg);
    check_value("stall_o.id", 0, stall.id_stg);
    check_value("deassert_we_o", 0, deassert_we);
    // jalr target still being written back
    @(negedge clk);
    set_quiet_inputs();
    dec.jump = JALR;
    dec.insn[`CTRL_RS1_LSB +: `CTRL_REG_AW] = 5'd7;
    dec.rega_used = 1'b1;
    wr.wb.addr    = 5'd7;
    wr.wb.we      = 1'b1;
    #1;
    check_value("stall_o.if", 1, stall.if_stg);
    check_value("stall_o.id", 1, stall.id_stg);
    check_value("deassert_we_o", 1, deassert_we);
    check_value("pc_sel_o", PC_JUMP, pc_sel);
    @(negedge clk);
    wr.wb.addr = 5'd9;
    #1;
    check_value("stall_o.if", 0, stall.if_stg);
    check_value("stall_o.id", 0, stall.id_stg);
    check_value("deassert_we_o", 0, deassert_we);
    // illegal instruction kills the write but does not stall
    @(negedge clk);
    set_quiet_inputs();
    dec.illegal = 1'b1;
    #1;
    check_value("illegal_insn_o", 1, illegal_insn);
    check_value("deassert_we_o", 1, deassert_we);
    check_value("stall_o.id", 0, stall.id_stg);
    @(negedge clk);
    set_quiet_inputs();
    end_test();
  endtask

  task automatic test_backpressure();
    start_test("backpressure");
    @(negedge clk);
    lsu_ready_wb = 1'b0;
    #1;
    check_value("stall_o", 4'b1111, stall);
    @(negedge clk);
    lsu_ready_wb = 1'b1;
    lsu_ready_ex = 1'b0;
    #1;
    check_value("stall_o", 4'b1110, stall);
    @(negedge clk);
    lsu_ready_ex = 1'b1;
    #1;
    check_value("stall_o", 4'b0000, stall);
    end_test();
  endtask

  task automatic test_branch_exception();
    start_test("branch_exc");
    // taken branch
    @(negedge clk);
    dec.jump   = COND;
    jump_in_id = COND;
    #1;
    check_value("stall_o.if", 1, stall.if_stg);
    check_value("stall_o.id", 0, stall.id_stg);
    @(negedge clk);
    dec.jump        = NONE;
    jump_in_id      = NONE;
    jump_in_ex      = COND;
    branch_decision = 1'b1;
    #1;
    check_value("is_decoding_o", 0, is_decoding);
    check_value("pc_sel_o", PC_BRANCH, pc_sel);
    @(negedge clk);
    jump_in_ex      = NONE;
    branch_decision = 1'b0;
    #1;
    check_value("is_decoding_o", 1, is_decoding);
    // not taken gives no redirect
    @(negedge clk);
    dec.jump   = COND;
    jump_in_id = COND;
    @(negedge clk);
    dec.jump   = NONE;
    jump_in_id = NONE;
    jump_in_ex = COND;
    #1;
    check_value("is_decoding_o", 0, is_decoding);
    check_value("pc_set_o", 0, pc_set);
    if (pc_sel == PC_BRANCH)
    begin
      $display("ERROR test=%s: not-taken branch still selects the branch target",
               cur_test);
      test_errors++;
    end
    @(negedge clk);
    jump_in_ex = NONE;
    #1;
    check_value("is_decoding_o", 1, is_decoding);
    // exception redirect
    @(negedge clk);
    exc_pc_sel = 1'b1;
    #1;
    check_value("pc_set_o", 1, pc_set);
    check_value("pc_sel_o", PC_EXCEPTION, pc_sel);
    @(negedge clk);
    exc_pc_sel = 1'b0;
    #1;
    check_value("pc_set_o", 0, pc_set);
    end_test();
  endtask

  task automatic test_flush_sleep();
    start_test("flush_sleep");
    @(negedge clk);
    fetch_enable   = 1'b0;
    dec.pipe_flush = 1'b1;
    #1;
    // front end halted while the flush starts
    check_value("stall_o.if", 1, stall.if_stg);
    check_value("stall_o.id", 1, stall.id_stg);
    @(negedge clk);
    dec.pipe_flush = 1'b0;
    wait_level("core_busy_o", OBS_BUSY, 1'b0, 8);
    check_value("instr_req_o", 0, instr_req);
    check_value("deassert_we_o", 1, deassert_we);
    // stays asleep without a wake source
    @(negedge clk);
    #1;
    check_value("core_busy_o", 0, core_busy);
    @(negedge clk);
    irq_present = 1'b1;
    @(negedge clk);
    irq_present = 1'b0;
    wait_level("instr_req_o", OBS_REQ, 1'b1, 8);
    wait_level("is_decoding_o", OBS_DECODING, 1'b1, 8);
    end_test();
  endtask

  //////////////////////////////////////////////////////////////////////
  // main sequence and watchdog
  //////////////////////////////////////////////////////////////////////

  initial
  begin
    lfsr_q       = 16'd69;
    test_errors  = 0;
    total_errors = 0;
    tests_run    = 0;
    tests_failed = 0;
    fetch_enable = 1'b0;
    instr_ack    = 1'b0;
    set_quiet_inputs();
    wait (rst_n === 1'b1);
    #1;
    test_boot();
    test_forwarding();
    test_hazards();
    test_backpressure();
    test_branch_exception();
    test_flush_sleep();
    $display("tests run %0d, tests failed %0d, errors %0d",
             tests_run, tests_failed, total_errors);
    if (total_errors == 0)
    begin
      $display("Verification passed");
    end
    else
    begin
      $display("Verification failed");
    end
    $finish;
  end

  initial
  begin
    #(WATCHDOG_NS);
    $display("watchdog expired in test %s, the run did not finish in time", cur_test);
    $display("Verification failed");
    $finish;
  end

endmodule

/* tests/core_controller_properties.sv */
module core_controller_properties
  import ctrl_types_pkg::*;
(
  input logic    clk,
  input logic    rst_n,
  input logic    pc_set_i,
  input pc_sel_e pc_sel_i,
  input logic    instr_req_i,
  input logic    core_busy_i
);
  timeunit 1ns;
  timeprecision 100ps;

  // core_busy low means the fsm sits in reset or sleep
  a_no_pc_set_idle : assert property (
    @(posedge clk) disable iff (!rst_n) !core_busy_i |-> !pc_set_i
  ) else $error("pc_set_o high while the core is idle");

  // no fetch while idle
  a_no_req_idle : assert property (
    @(posedge clk) disable iff (!rst_n) !core_busy_i |-> !instr_req_i
  ) else $error("instr_req_o high while core_busy_o is low");

  // boot address load is a single cycle pulse
  a_boot_one_cycle : assert property (
    @(posedge clk) disable iff (!rst_n)
    (pc_set_i && (pc_sel_i == PC_BOOT)) |=> !(pc_set_i && (pc_sel_i == PC_BOOT))
  ) else $error("boot pc set held for more than one cycle");

endmodule

bind core_controller core_controller_properties u_props (
  .clk         (clk),
  .rst_n       (rst_n),
  .pc_set_i    (pc_set_o),
  .pc_sel_i    (pc_sel_o),
  .instr_req_i (instr_req_o),
  .core_busy_i (core_busy_o)
);

/* tests/clk_gen.sv */
module clk_gen (
  output logic clk,
  output logic rst_n
);
  timeunit 1ns;
  timeprecision 100ps;

  // 20 ns period
  initial
  begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // reset low for five rising edges, released on a falling edge
  initial
  begin
    rst_n = 1'b0;
    repeat (5) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
  end

endmodule

/* rtl/core_controller.sv */
module core_controller
  import ctrl_types_pkg::*;
  import hazard_types_pkg::*;
(
  input  logic         clk,
  input  logic         rst_n,
  // decoder and later stages
  input  decode_info_t dec_i,
  input  wr_ports_t    wr_i,
  input  jump_kind_e   jump_in_id_i,
  input  jump_kind_e   jump_in_ex_i,
  // levels
  input  logic         branch_decision_i,
  input  logic         exc_pc_sel_i,
  input  logic         pc_valid_i,
  input  logic         lsu_ready_ex_i,
  input  logic         lsu_ready_wb_i,
  input  logic         fetch_enable_i,
  input  logic         irq_present_i,
  // fetch handshake and pc control
  input  logic         instr_ack_i,
  output logic         instr_req_o,
  output logic         pc_set_o,
  output pc_sel_e      pc_sel_o,
  // status
  output logic         core_busy_o,
  output logic         is_decoding_o,
  output logic         illegal_insn_o,
  // pipeline control
  output fwd_sel_t     fwd_sel_o,
  output stall_t       stall_o,
  output logic         deassert_we_o
);

  logic    halt_if;
  logic    halt_id;
  logic    in_decode;
  hazard_t hazard;

  // sequencing fsm, reads the stalls back
  ctrl_fsm u_fsm (
    .clk               (clk),
    .rst_n             (rst_n),
    .fetch_enable_i    (fetch_enable_i),
    .irq_present_i     (irq_present_i),
    .instr_ack_i       (instr_ack_i),
    .dec_i             (dec_i),
    .jump_in_ex_i      (jump_in_ex_i),
    .branch_decision_i (branch_decision_i),
    .exc_pc_sel_i      (exc_pc_sel_i),
    .stall_i           (stall_o),
    .instr_req_o       (instr_req_o),
    .pc_set_o          (pc_set_o),
    .pc_sel_o          (pc_sel_o),
    .core_busy_o       (core_busy_o),
    .is_decoding_o     (is_decoding_o),
    .in_decode_o       (in_decode),
    .illegal_insn_o    (illegal_insn_o),
    .halt_if_o         (halt_if),
    .halt_id_o         (halt_id)
  );

  // register compare, forwarding and hazards
  hazard_unit u_hazard (
    .dec_i     (dec_i),
    .wr_i      (wr_i),
    .fwd_sel_o (fwd_sel_o),
    .hazard_o  (hazard)
  );

  freeze_unit u_freeze (
    .hazard_i       (hazard),
    .halt_if_i      (halt_if),
    .halt_id_i      (halt_id),
    .in_decode_i    (in_decode),
    .illegal_i      (illegal_insn_o),
    .instr_ack_i    (instr_ack_i),
    .lsu_ready_ex_i (lsu_ready_ex_i),
    .lsu_ready_wb_i (lsu_ready_wb_i),
    .pc_valid_i     (pc_valid_i),
    .jump_in_id_i   (jump_in_id_i),
    .stall_o        (stall_o),
    .deassert_we_o  (deassert_we_o)
  );

endmodule

/* rtl/freeze_unit.sv */
module freeze_unit
  import ctrl_types_pkg::*;
  import hazard_types_pkg::*;
(
  input  hazard_t    hazard_i,
  input  logic       halt_if_i,
  input  logic       halt_id_i,
  input  logic       in_decode_i,
  input  logic       illegal_i,
  input  logic       instr_ack_i,
  input  logic       lsu_ready_ex_i,
  input  logic       lsu_ready_wb_i,
  input  logic       pc_valid_i,
  input  jump_kind_e jump_in_id_i,
  output stall_t     stall_o,
  output logic       deassert_we_o
);

  logic fetch_miss;
  logic lsu_busy;
  logic reg_hazard;

  // common stall terms
  assign fetch_miss = !instr_ack_i;
  assign lsu_busy   = !lsu_ready_ex_i || !lsu_ready_wb_i;
  assign reg_hazard = hazard_i.load_use || hazard_i.jr;

  //////////////////////////////////////////////////////////////////////
  // stage freezes, later stages see fewer causes
  //////////////////////////////////////////////////////////////////////

  // if also holds on a bad pc and while a branch waits in id
  assign stall_o.if_stg = fetch_miss || reg_hazard || lsu_busy || halt_if_i ||
                          !pc_valid_i || (jump_in_id_i == COND);
  assign stall_o.id_stg = fetch_miss || reg_hazard || lsu_busy || halt_id_i;
  assign stall_o.ex_stg = fetch_miss || lsu_busy;
  assign stall_o.wb_stg = !lsu_ready_wb_i;

  // kill the register write of the instruction leaving decode
  assign deassert_we_o = !in_decode_i || illegal_i || reg_hazard;

endmodule

/* rtl/hazard_unit.sv */
`include "ctrl_cfg.svh"

module hazard_unit
  import ctrl_types_pkg::*;
  import hazard_types_pkg::*;
(
  input  decode_info_t dec_i,
  input  wr_ports_t    wr_i,
  output fwd_sel_t     fwd_sel_o,
  output hazard_t      hazard_o
);

  jump_kind_e jump_in_dec;
  reg_addr_t  rs1;
  reg_addr_t  rs2;
  reg_addr_t  rd;

  // per write port, does it hit operand a / b / c
  logic ex_is_a;
  logic ex_is_b;
  logic ex_is_c;
  logic wb_is_a;
  logic wb_is_b;
  logic wb_is_c;
  logic alu_is_a;
  logic alu_is_b;

  // address hit, only counts when the operand is really read
  function automatic logic addr_match(input reg_addr_t wr_addr,
                                      input reg_addr_t rd_addr,
                                      input logic      used);
    return (wr_addr == rd_addr) && used;
  endfunction

  //////////////////////////////////////////////////////////////////////
  // field extraction and address compare
  //////////////////////////////////////////////////////////////////////

  assign jump_in_dec = dec_i.jump;
  assign rs1 = dec_i.insn[`CTRL_RS1_LSB +: `CTRL_REG_AW];
  assign rs2 = dec_i.insn[`CTRL_RS2_LSB +: `CTRL_REG_AW];
  // rd doubles as the third source for three-operand ops
  assign rd  = dec_i.insn[`CTRL_RD_LSB +: `CTRL_REG_AW];

  assign ex_is_a  = addr_match(wr_i.ex.addr, rs1, dec_i.rega_used);
  assign ex_is_b  = addr_match(wr_i.ex.addr, rs2, dec_i.regb_used);
  assign ex_is_c  = addr_match(wr_i.ex.addr, rd, dec_i.regc_used);
  assign wb_is_a  = addr_match(wr_i.wb.addr, rs1, dec_i.rega_used);
  assign wb_is_b  = addr_match(wr_i.wb.addr, rs2, dec_i.regb_used);
  assign wb_is_c  = addr_match(wr_i.wb.addr, rd, dec_i.regc_used);
  assign alu_is_a = addr_match(wr_i.alu.addr, rs1, dec_i.rega_used);
  assign alu_is_b = addr_match(wr_i.alu.addr, rs2, dec_i.regb_used);

  //////////////////////////////////////////////////////////////////////
  // forwarding selects
  //////////////////////////////////////////////////////////////////////

  always_comb
  begin
    fwd_sel_o.a = SEL_REGFILE;
    fwd_sel_o.b = SEL_REGFILE;
    fwd_sel_o.c = SEL_REGFILE;

    // older result from wb first
    if (wr_i.wb.we)
    begin
      if (wb_is_a)
      begin
        fwd_sel_o.a = SEL_FW_WB;
      end
      if (wb_is_b)
      begin
        fwd_sel_o.b = SEL_FW_WB;
      end
      if (wb_is_c)
      begin
        fwd_sel_o.c = SEL_FW_WB;
      end
    end

    // younger alu result overrides, operand c has no alu path
    if (wr_i.alu.we)
    begin
      if (alu_is_a)
      begin
        fwd_sel_o.a = SEL_FW_EX;
      end
      if (alu_is_b)
      begin
        fwd_sel_o.b = SEL_FW_EX;
      end
    end

    // x0 reads as zero from the register file
    if (rs1 == '0)
    begin
      fwd_sel_o.a = SEL_REGFILE;
    end
    if (rs2 == '0)
    begin
      fwd_sel_o.b = SEL_REGFILE;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // stall causes
  //////////////////////////////////////////////////////////////////////

  // load in ex whose data is not back yet
  assign hazard_o.load_use = wr_i.data_req_ex && wr_i.ex.we &&
                             (ex_is_a || ex_is_b || ex_is_c);

  // jalr target register still in flight anywhere
  assign hazard_o.jr = (jump_in_dec == JALR) &&
                       ((wr_i.wb.we && wb_is_a) ||
                        (wr_i.ex.we && ex_is_a) ||
                        (wr_i.alu.we && alu_is_a));

endmodule

/* rtl/ctrl_fsm.sv */
module ctrl_fsm
  import ctrl_types_pkg::*;
(
  input  logic         clk,
  input  logic         rst_n,
  input  logic         fetch_enable_i,
  input  logic         irq_present_i,
  input  logic         instr_ack_i,
  input  decode_info_t dec_i,
  input  jump_kind_e   jump_in_ex_i,
  input  logic         branch_decision_i,
  input  logic         exc_pc_sel_i,
  input  stall_t       stall_i,
  output logic         instr_req_o,
  output logic         pc_set_o,
  output pc_sel_e      pc_sel_o,
  output logic         core_busy_o,
  output logic         is_decoding_o,
  output logic         in_decode_o,
  output logic         illegal_insn_o,
  output logic         halt_if_o,
  output logic         halt_id_o
);

  ctrl_state_e state_q;
  ctrl_state_e state_d;

  //////////////////////////////////////////////////////////////////////
  // next state and per-state decisions
  //////////////////////////////////////////////////////////////////////

  always_comb
  begin
    // defaults describe a running core with nothing special going on
    state_d        = state_q;
    instr_req_o    = 1'b1;
    pc_set_o       = 1'b0;
    pc_sel_o       = PC_BOOT;
    core_busy_o    = 1'b1;
    is_decoding_o  = 1'b0;
    illegal_insn_o = 1'b0;
    halt_if_o      = 1'b0;
    halt_id_o      = 1'b0;

    case (state_q)
      // idle after reset until fetching is allowed
      RESET:
      begin
        core_busy_o = 1'b0;
        instr_req_o = 1'b0;
        if (fetch_enable_i)
        begin
          state_d = BOOT_SET;
        end
      end

      // load the boot address into the fetch pc for one cycle only
      BOOT_SET:
      begin
        pc_set_o = 1'b1;
        pc_sel_o = PC_BOOT;
        state_d  = FIRST_FETCH;
      end

      // asleep until enable or a pending interrupt
      SLEEP:
      begin
        core_busy_o = 1'b0;
        instr_req_o = 1'b0;
        if (fetch_enable_i || irq_present_i)
        begin
          state_d = FIRST_FETCH;
        end
      end

      // wait for the first instruction to arrive
      FIRST_FETCH:
      begin
        if (instr_ack_i)
        begin
          state_d = DECODE;
        end
      end

      DECODE:
      begin
        is_decoding_o = 1'b1;

        // conditional branch resolves in ex so follow it there
        if ((dec_i.jump == COND) && !stall_i.id_stg)
        begin
          state_d = BRANCH;
        end

        // jal and jalr targets are known already
        // prefetch buffer drops the fall-through on its own
        if ((dec_i.jump == JAL) || (dec_i.jump == JALR))
        begin
          pc_sel_o = PC_JUMP;
        end

        if (dec_i.illegal)
        begin
          illegal_insn_o = 1'b1;
        end

        // exception handler redirect wins over a jump
        if (exc_pc_sel_i)
        begin
          pc_set_o = 1'b1;
          pc_sel_o = PC_EXCEPTION;
        end

        // wfi style flush freezes the front end and drains ex and wb
        if (dec_i.pipe_flush || dec_i.exc_flush)
        begin
          halt_if_o = 1'b1;
          halt_id_o = 1'b1;
          state_d   = FLUSH_EX;
        end
      end

      // branch instruction now sits in ex with its decision
      BRANCH:
      begin
        if ((jump_in_ex_i == COND) && branch_decision_i)
        begin
          // taken
          pc_sel_o = PC_BRANCH;
        end
        if (!stall_i.id_stg)
        begin
          state_d = DECODE;
        end
      end

      // let the instruction in ex move on
      FLUSH_EX:
      begin
        halt_if_o = 1'b1;
        halt_id_o = 1'b1;
        if (!stall_i.ex_stg)
        begin
          state_d = FLUSH_WB;
        end
      end

      // wb drains here before sleep or resume
      FLUSH_WB:
      begin
        halt_if_o = 1'b1;
        halt_id_o = 1'b1;
        if (!fetch_enable_i)
        begin
          if (!stall_i.wb_stg)
          begin
            state_d = SLEEP;
          end
        end
        else
        begin
          // still enabled so release the front end
          halt_if_o = 1'b0;
          halt_id_o = 1'b0;
          if (!stall_i.id_stg)
          begin
            state_d = DECODE;
          end
        end
      end

      default:
      begin
        instr_req_o = 1'b0;
        state_d     = RESET;
      end
    endcase
  end

  // the freeze unit only needs to know whether decode is live
  assign in_decode_o = (state_q == DECODE);

  //////////////////////////////////////////////////////////////////////
  // state register
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state_q <= RESET;
    end
    else
    begin
      state_q <= state_d;
    end
  end

endmodule

/* rtl/hazard_types_pkg.sv */
`include "ctrl_cfg.svh"

package hazard_types_pkg;

  //////////////////////////////////////////////////////////////////////
  // register side encodings
  //////////////////////////////////////////////////////////////////////

  // index into the register file
  typedef logic [`CTRL_REG_AW-1:0] reg_addr_t;

  // operand source for the id stage read mux
  typedef enum logic [1:0] {
    SEL_REGFILE = 2'b00,
    SEL_FW_EX   = 2'b01,
    SEL_FW_WB   = 2'b10
  } fwd_sel_e;

  //////////////////////////////////////////////////////////////////////
  // bundles
  //////////////////////////////////////////////////////////////////////

  // a single register write port of a later stage
  typedef struct packed {
    reg_addr_t addr;
    logic      we;
  } wr_port_t;

  // all write ports visible from decode
  // alu is the early result path out of ex
  typedef struct packed {
    wr_port_t ex;
    wr_port_t wb;
    wr_port_t alu;
    logic     data_req_ex;
  } wr_ports_t;

  // read mux selects for operands a, b and c
  typedef struct packed {
    fwd_sel_e a;
    fwd_sel_e b;
    fwd_sel_e c;
  } fwd_sel_t;

  // stall causes found by register comparison
  typedef struct packed {
    logic load_use;
    logic jr;
  } hazard_t;

endpackage

/* rtl/ctrl_types_pkg.sv */
`include "ctrl_cfg.svh"

package ctrl_types_pkg;

  //////////////////////////////////////////////////////////////////////
  // control flow encodings
  //////////////////////////////////////////////////////////////////////

  // sequencing states of the main controller
  typedef enum logic [3:0] {
    RESET       = 4'd0,
    BOOT_SET    = 4'd1,
    SLEEP       = 4'd2,
    FIRST_FETCH = 4'd3,
    DECODE      = 4'd4,
    BRANCH      = 4'd5,
    FLUSH_EX    = 4'd6,
    FLUSH_WB    = 4'd7
  } ctrl_state_e;

  // source of the next pc in the fetch stage
  typedef enum logic [2:0] {
    PC_BOOT      = 3'b000,
    PC_JUMP      = 3'b010,
    PC_BRANCH    = 3'b011,
    PC_EXCEPTION = 3'b100
  } pc_sel_e;

  // kind of control transfer seen in a stage
  typedef enum logic [1:0] {
    NONE = 2'b00,
    JAL  = 2'b01,
    JALR = 2'b10,
    COND = 2'b11
  } jump_kind_e;

  // raw instruction held in the decode stage
  typedef logic [`CTRL_INSN_W-1:0] insn_word_t;

  //////////////////////////////////////////////////////////////////////
  // bundles
  //////////////////////////////////////////////////////////////////////

  // everything the decoder tells the controller
  typedef struct packed {
    insn_word_t insn;
    jump_kind_e jump;
    logic       illegal;
    logic       pipe_flush;
    logic       exc_flush;
    logic       rega_used;
    logic       regb_used;
    logic       regc_used;
  } decode_info_t;

  // one freeze bit per pipeline stage
  typedef struct packed {
    logic if_stg;
    logic id_stg;
    logic ex_stg;
    logic wb_stg;
  } stall_t;

endpackage

/* include/ctrl_cfg.svh */
`ifndef CTRL_CFG_SVH
`define CTRL_CFG_SVH

//////////////////////////////////////////////////////////////////////
// instruction word geometry
//////////////////////////////////////////////////////////////////////

// width of one fetched instruction
`define CTRL_INSN_W 32

// register file has 32 entries
`define CTRL_REG_AW 5

//////////////////////////////////////////////////////////////////////
// register field positions inside the instruction word
//////////////////////////////////////////////////////////////////////

// rs1 lives in bits 19:15
`define CTRL_RS1_LSB 15

// rs2 lives in bits 24:20
`define CTRL_RS2_LSB 20

// rd lives in bits 11:7, also read as operand c
`define CTRL_RD_LSB 7

`endif
